// ==== rtl/tx_defines.svh ====
`ifndef TX_DEFINES_SVH
`define TX_DEFINES_SVH

// Parallel word entering on each word strobe
`define TX_WORD_W 16

// Quarter-rate lanes and bits per lane
`define TX_LANES  4
`define TX_LANE_W 4

// Phase code width, delays of 0 to 3 bit periods
`define TX_NPI    2

`endif

// ==== rtl/tx_data_pkg.sv ====
`default_nettype none

`include "tx_defines.svh"

package tx_data_pkg;

    // One quarter-rate lane
    // MSB leaves the serializer first
    typedef logic [`TX_LANE_W-1:0] qr_lane_t;

    // One reordered word, lane-major
    // Lane k sits at bits 4k+3 down to 4k of the flat view
    typedef union packed {
        logic [`TX_WORD_W-1:0]    flat;   // Capture and inversion view
        qr_lane_t [`TX_LANES-1:0] lanes;  // Hand-out view for the 4 to 1 stage
    } tx_word_u;

endpackage

`default_nettype wire

// ==== rtl/tx_ctl_pkg.sv ====
`default_nettype none

`include "tx_defines.svh"

package tx_ctl_pkg;

    // Output delay in whole bit periods
    typedef logic [`TX_NPI-1:0] pi_code_t;

    // Bit slot within a word
    // Wraps naturally after the last slot
    typedef logic [$clog2(`TX_WORD_W)-1:0] div_count_t;

endpackage

`default_nettype wire

// ==== rtl/input_divider.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tx_defines.svh"

// Turns the bit clock into quarter-rate and word-rate strobes
// Both strobes are one mdll_clk cycle wide
module input_divider (
    input  logic mdll_clk,     // Bit-rate clock
    input  logic reset,        // Synchronous active-high reset
    output logic word_stb,     // Last bit slot of a word
    output logic quarter_stb   // Last bit slot of a lane
);

    import tx_ctl_pkg::*;

    // Counter bits that select the slot inside one lane
    localparam int LANE_BITS = $clog2(`TX_LANE_W);

    div_count_t count_q;  // Current bit slot

    // Free running count that rolls over from 15 to 0
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // Strobes decoded straight from the count
    assign quarter_stb = &count_q[LANE_BITS-1:0];  // Slots 3, 7, 11, 15
    assign word_stb    = &count_q;                 // Slot 15 only

    // A word boundary is also a lane boundary
    a_word_has_quarter: assert property (
        @(posedge mdll_clk) disable iff (reset)
        word_stb |-> quarter_stb
    );

endmodule

`default_nettype wire

// ==== rtl/hr_16t4_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tx_defines.svh"

// 16 to 4 stage
// Holds one word and feeds it out one lane per quarter strobe
module hr_16t4_mux #(
    parameter logic IDLE_BIT = 1'b0  // Line level before the first word
) (
    input  logic                  mdll_clk,
    input  logic                  reset,
    input  logic                  word_stb,     // Capture din on this edge
    input  logic                  quarter_stb,  // Move on to the next lane
    input  logic [`TX_WORD_W-1:0] din,
    output tx_data_pkg::qr_lane_t lane         // Lane for the 4 to 1 stage
);

    import tx_data_pkg::*;

    localparam int PTR_W = $clog2(`TX_LANES);
    localparam logic [PTR_W-1:0] FIRST_LANE = PTR_W'(`TX_LANES - 1);  // Lane 3 leaves first

    logic [`TX_WORD_W-1:0] din_reorder;  // Interleaved, lane k on bits k, k+4, k+8, k+12
    tx_word_u              word_d;       // Same bits gathered per lane
    tx_word_u              word_q;       // Word being sent
    logic [PTR_W-1:0]      lane_ptr;     // Lane on the output now
    logic [PTR_W-1:0]      ptr_step;     // Next lane down

    // Interleave map
    // din_reorder[0] <- din[15], din_reorder[4] <- din[14] and so on
    // Lanes go out 3, 2, 1, 0, so din[0] is sent first
    always_comb begin
        for (int k = 0; k < `TX_LANES; k++) begin
            for (int j = 0; j < `TX_LANE_W; j++) begin
                din_reorder[k + `TX_LANES*j] = din[`TX_WORD_W - 1 - `TX_LANE_W*k - j];
            end
        end
    end

    // Gather every fourth bit into one lane, highest index sent first
    always_comb begin
        for (int k = 0; k < `TX_LANES; k++) begin
            for (int j = 0; j < `TX_LANE_W; j++) begin
                word_d.lanes[k][j] = din_reorder[k + `TX_LANES*j];
            end
        end
    end

    // Word register
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            word_q.flat <= {`TX_WORD_W{IDLE_BIT}};  // Idle line until the first word
        end else if (word_stb) begin
            word_q.flat <= word_d.flat;
        end
    end

    assign ptr_step = lane_ptr - 1'b1;

    // Lane pointer counts down 3, 2, 1, 0
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            lane_ptr <= FIRST_LANE;
        end else if (word_stb) begin
            lane_ptr <= FIRST_LANE;  // Restart with the new word
        end else if (quarter_stb) begin
            lane_ptr <= ptr_step;
        end
    end

    assign lane = word_q.lanes[lane_ptr];  // Taken by the 4 to 1 stage on quarter_stb

    // All four lanes handed out by the time the next word lands
    a_ptr_wrapped: assert property (
        @(posedge mdll_clk) disable iff (reset)
        word_stb |-> ptr_step == FIRST_LANE
    );

endmodule

`default_nettype wire

// ==== rtl/qr_4t1_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tx_defines.svh"

// 4 to 1 stage
// Loads one lane per quarter strobe and sends it MSB first
module qr_4t1_mux #(
    parameter logic IDLE_BIT = 1'b0  // Level shifted in behind the lane
) (
    input  logic                  mdll_clk,
    input  logic                  reset,
    input  logic                  quarter_stb,  // Load a fresh lane
    input  tx_data_pkg::qr_lane_t lane,         // From the 16 to 4 stage
    output logic                  ser_bit       // One bit per mdll_clk
);

    import tx_data_pkg::*;

    qr_lane_t shift_q;  // Lane being sent, MSB on the line

    // The load lands every 4th cycle
    // So the fill bits never reach ser_bit
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            shift_q <= {`TX_LANE_W{IDLE_BIT}};
        end else if (quarter_stb) begin
            shift_q <= lane;  // First bit visible next cycle
        end else begin
            shift_q <= {shift_q[`TX_LANE_W-2:0], IDLE_BIT};  // Move up toward the MSB
        end
    end

    assign ser_bit = shift_q[`TX_LANE_W-1];

endmodule

`default_nettype wire

// ==== rtl/phase_select.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tx_defines.svh"

// Output phase stage
// Delays both serial streams by a whole number of bit periods
// and drives the complementary pair
module phase_select (
    input  logic                 mdll_clk,
    input  logic                 reset,
    input  logic                 word_stb,   // Word boundary, code switch point
    input  tx_ctl_pkg::pi_code_t ctl_pi,     // Requested delay
    input  logic                 ctl_valid,  // ctl_pi is valid this cycle
    input  logic                 ser_p,      // Serial stream, positive chain
    input  logic                 ser_n,      // Serial stream, negative chain
    output logic                 dout_p,
    output logic                 dout_n
);

    import tx_ctl_pkg::*;

    localparam int NTAP = 1 << `TX_NPI;  // Delays 0 to 3

    pi_code_t        pi_pend_q;         // Last code received
    pi_code_t        pi_act_q;          // Code in use
    logic [NTAP-2:0] dly_p_q;           // Bit k is k+1 cycles old
    logic [NTAP-2:0] dly_n_q;
    logic [NTAP-1:0] tap_p;             // Tap k is k cycles old
    logic [NTAP-1:0] tap_n;

    // Codes are only switched between words
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            pi_pend_q <= '0;
            pi_act_q  <= '0;
        end else begin
            if (ctl_valid) begin
                pi_pend_q <= ctl_pi;
            end
            if (word_stb) begin
                pi_act_q <= pi_pend_q;  // Code from the same cycle waits a word
            end
        end
    end

    // Delay lines, one per polarity
    always_ff @(posedge mdll_clk) begin
        dly_p_q <= {dly_p_q[NTAP-3:0], ser_p};
        dly_n_q <= {dly_n_q[NTAP-3:0], ser_n};
    end

    assign tap_p = {dly_p_q, ser_p};
    assign tap_n = {dly_n_q, ser_n};

    // Output register, adds one cycle on top of the code
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            dout_p <= 1'b0;
            dout_n <= 1'b1;
        end else begin
            dout_p <= tap_p[pi_act_q];
            dout_n <= tap_n[pi_act_q];
        end
    end

    // Both chains must stay exact complements
    a_diff_pair: assert property (
        @(posedge mdll_clk) disable iff (reset)
        dout_n == !dout_p
    );

endmodule

`default_nettype wire

// ==== rtl/tx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tx_defines.svh"

// Serializing link transmitter
// One 16-bit word in per word_stb, one bit out per mdll_clk
// din[0] goes out first and din[15] last
// First bit shows at dout_p 5 + code cycles after the sampling edge
//   16 to 4 capture           1
//   wait for the quarter strobe 3
//   4 to 1 load                1
//   phase stage                code
module tx_top (
    input  logic                  mdll_clk,   // Bit-rate clock
    input  logic                  reset,      // Sync, active high
    input  logic [`TX_WORD_W-1:0] din,        // Sampled on the word_stb edge
    input  tx_ctl_pkg::pi_code_t  ctl_pi,     // Output delay in bit periods
    input  logic                  ctl_valid,  // Load ctl_pi
    output logic                  word_stb,   // Word request to the source
    output logic                  dout_p,     // Serial out, positive
    output logic                  dout_n      // Serial out, negative
);

    import tx_data_pkg::*;

    logic                  quarter_stb;
    logic [`TX_WORD_W-1:0] din_n;   // Inverted word for the negative chain
    qr_lane_t              lane_p;
    qr_lane_t              lane_n;
    logic                  ser_p;
    logic                  ser_n;

    assign din_n = ~din;

    input_divider indiv (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .word_stb    (word_stb),
        .quarter_stb (quarter_stb)
    );

    // Positive chain
    hr_16t4_mux #(.IDLE_BIT(1'b0)) hr_mux_16t4_0 (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .word_stb    (word_stb),
        .quarter_stb (quarter_stb),
        .din         (din),
        .lane        (lane_p)
    );

    qr_4t1_mux #(.IDLE_BIT(1'b0)) qr_mux_4t1_0 (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .quarter_stb (quarter_stb),
        .lane        (lane_p),
        .ser_bit     (ser_p)
    );

    // Negative chain, idles high
    hr_16t4_mux #(.IDLE_BIT(1'b1)) hr_mux_16t4_1 (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .word_stb    (word_stb),
        .quarter_stb (quarter_stb),
        .din         (din_n),
        .lane        (lane_n)
    );

    qr_4t1_mux #(.IDLE_BIT(1'b1)) qr_mux_4t1_1 (
        .mdll_clk    (mdll_clk),
        .reset       (reset),
        .quarter_stb (quarter_stb),
        .lane        (lane_n),
        .ser_bit     (ser_n)
    );

    phase_select phase_sel (
        .mdll_clk  (mdll_clk),
        .reset     (reset),
        .word_stb  (word_stb),
        .ctl_pi    (ctl_pi),
        .ctl_valid (ctl_valid),
        .ser_p     (ser_p),
        .ser_n     (ser_n),
        .dout_p    (dout_p),
        .dout_n    (dout_n)
    );

endmodule

`default_nettype wire

// ==== verif/tb_tx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "tx_defines.svh"

// Directed testbench for the serializing transmitter
module tb_tx_top;

    import tx_data_pkg::*;
    import tx_ctl_pkg::*;

    localparam int CLK_HALF    = 2;                // 4 ns bit clock
    localparam int RESET_CYC   = 8;
    localparam int FIRST_BIT   = 5;                // Sampling edge to first bit at code 0
    localparam int STB_TIMEOUT = 2 * `TX_WORD_W;   // Cycles allowed between word strobes
    localparam int MAX_WORDS   = 16;

    logic                  mdll_clk;
    logic                  reset;
    logic [`TX_WORD_W-1:0] din;
    pi_code_t              ctl_pi;
    logic                  ctl_valid;
    logic                  word_stb;
    logic                  dout_p;
    logic                  dout_n;

    logic [31:0]           lfsr_state = 32'h6ff6_1d4a;
    logic [`TX_WORD_W-1:0] tx_words[$];              // Words for the next run
    tx_word_u              rx_buf [0:MAX_WORDS-1];   // Rebuilt from dout_p
    div_count_t            cnt_model;                // Expected divider count

    tx_top dut (
        .mdll_clk  (mdll_clk),
        .reset     (reset),
        .din       (din),
        .ctl_pi    (ctl_pi),
        .ctl_valid (ctl_valid),
        .word_stb  (word_stb),
        .dout_p    (dout_p),
        .dout_n    (dout_n)
    );

    initial begin
        mdll_clk = 1'b0;
        forever #(CLK_HALF) mdll_clk = ~mdll_clk;
    end

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0.1f ns: %s expected %b, got %b", $realtime, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input tx_word_u exp, input tx_word_u act);
        if (act.flat !== exp.flat) begin
            $display("ERROR at %0.1f ns: %s expected %h, got %h",
                     $realtime, name, exp.flat, act.flat);
            stop_on_error();
        end
    endtask

    task automatic check_code(input string name, input pi_code_t exp, input pi_code_t act);
        if (act !== exp) begin
            $display("ERROR at %0.1f ns: %s expected %0d, got %0d", $realtime, name, exp, act);
            stop_on_error();
        end
    endtask

    // Fibonacci taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [`TX_WORD_W-1:0] random_word();
        logic [`TX_WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < `TX_WORD_W; i++) begin
            w = {w[`TX_WORD_W-2:0], lfsr_next_bit()};  // One step per bit
        end
        return w;
    endfunction

    // Returns on the sampling edge so the caller drives the following din
    task automatic wait_word_stb();
        int waited;
        waited = 0;
        do begin
            @(negedge mdll_clk);
            waited++;
            if (waited > STB_TIMEOUT) begin
                $display("Timeout, word_stb did not fire within %0d cycles", STB_TIMEOUT);
                stop_on_error();
            end
        end while (word_stb !== 1'b1);
        @(posedge mdll_clk);
    endtask

    // Streams tx_words back to back and rebuilds them from dout_p into rx_buf
    // The word already in flight straddles any code switch and is not rebuilt
    task automatic run_words(input pi_code_t code, input bit load_code, output int first_one);
        int         n_words;
        int         last_t;
        int         rel;
        logic [3:0] widx;
        logic [3:0] pos;
        n_words   = tx_words.size();
        last_t    = `TX_WORD_W * (n_words + 1) + FIRST_BIT + int'(code) - 1;
        first_one = -1;
        wait_word_stb();
        din <= tx_words[0];
        if (load_code) begin
            ctl_pi    <= code;
            ctl_valid <= 1'b1;  // Active from the next word boundary
        end
        for (int t = 1; t <= last_t; t++) begin
            @(posedge mdll_clk);
            ctl_valid <= 1'b0;
            if (t % `TX_WORD_W == 0) begin  // Sampling edge of word t/16 - 1
                if (t / `TX_WORD_W < n_words) begin
                    din <= tx_words[t / `TX_WORD_W];
                end else begin
                    din <= '0;  // Quiet line after the last word
                end
            end
            @(negedge mdll_clk);
            check_bit("word_stb", (t % `TX_WORD_W) == `TX_WORD_W - 1, word_stb);
            check_bit("dout_n", ~dout_p, dout_n);  // Complementary pair
            if (first_one < 0 && dout_p === 1'b1) begin
                first_one = t;
            end
            rel = t - `TX_WORD_W - FIRST_BIT - int'(code);  // Bit index in the stream
            if (rel >= 0 && rel < `TX_WORD_W * n_words) begin
                widx = 4'(rel / `TX_WORD_W);
                pos  = 4'(rel % `TX_WORD_W);
                rx_buf[widx].lanes[pos[3:2]][pos[1:0]] = dout_p;  // Four bits per lane
            end
        end
    endtask

    // Rebuilt words against the words that were sent
    task automatic compare_words();
        tx_word_u exp_w;
        for (int j = 0; j < tx_words.size(); j++) begin
            exp_w.flat = tx_words[j];
            check_word($sformatf("word %0d", j), exp_w, rx_buf[4'(j)]);
        end
    endtask

    task automatic reset_state();
        for (int i = 0; i < RESET_CYC; i++) begin
            @(posedge mdll_clk);
            if (i == RESET_CYC - 1) begin
                reset <= 1'b0;  // DUT still sees reset on this edge
            end
            @(negedge mdll_clk);
            check_bit("word_stb", 1'b0, word_stb);
            check_bit("dout_p", 1'b0, dout_p);
            check_bit("dout_n", 1'b1, dout_n);
        end
        cnt_model = '0;
        @(posedge mdll_clk);
        cnt_model = cnt_model + 1'b1;
        @(negedge mdll_clk);  // First cycle out of reset
        check_bit("word_stb", 1'b0, word_stb);
        check_bit("dout_p", 1'b0, dout_p);
        check_bit("dout_n", 1'b1, dout_n);
    endtask

    task automatic strobe_cadence();
        int first_fire;
        first_fire = -1;
        for (int k = 2; k <= 3 * `TX_WORD_W; k++) begin
            @(posedge mdll_clk);
            cnt_model = cnt_model + 1'b1;  // Wraps at 15
            @(negedge mdll_clk);
            check_bit("word_stb", cnt_model == div_count_t'(`TX_WORD_W - 1), word_stb);
            if (first_fire < 0 && word_stb === 1'b1) begin
                first_fire = k;
            end
        end
        // Strobe is visible after edge k and sampled on edge k + 1
        if (first_fire + 1 != `TX_WORD_W) begin
            $display("First word_stb was sampled %0d edges after reset release, not %0d",
                     first_fire + 1, `TX_WORD_W);
            stop_on_error();
        end
    endtask

    task automatic serial_order();
        int first_one;
        tx_words.delete();
        tx_words.push_back(16'h0001);  // Lone first bit
        tx_words.push_back(16'h8000);  // Lone last bit
        tx_words.push_back(16'ha5c3);
        tx_words.push_back(16'h3c5a);
        run_words(pi_code_t'(0), 1'b0, first_one);
        compare_words();
    endtask

    task automatic streaming();
        int first_one;
        tx_words.delete();
        for (int i = 0; i < 10; i++) begin
            tx_words.push_back(random_word());
        end
        run_words(pi_code_t'(0), 1'b0, first_one);
        compare_words();
    endtask

    // Line is quiet before each run so the first one is the marker bit
    task automatic phase_codes();
        int first_one;
        int measured;
        for (int c = 0; c < (1 << `TX_NPI); c++) begin
            tx_words.delete();
            tx_words.push_back(random_word() | 16'h0001);  // Marker leaves first
            tx_words.push_back(random_word());
            tx_words.push_back(random_word());
            run_words(pi_code_t'(c), 1'b1, first_one);
            measured = first_one - `TX_WORD_W - FIRST_BIT;
            if (first_one < 0 || measured < 0 || measured >= (1 << `TX_NPI)) begin
                $display("Marker bit for code %0d was not seen inside the delay window", c);
                stop_on_error();
            end
            check_code("measured delay", pi_code_t'(c), pi_code_t'(measured));
            compare_words();
        end
    endtask

    initial begin
        reset     = 1'b1;
        din       = '0;
        ctl_pi    = '0;
        ctl_valid = 1'b0;
        reset_state();
        strobe_cadence();
        serial_order();
        streaming();
        phase_codes();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/tx_data_pkg.sv
rtl/tx_ctl_pkg.sv
rtl/input_divider.sv
rtl/hr_16t4_mux.sv
rtl/qr_4t1_mux.sv
rtl/phase_select.sv
rtl/tx_top.sv
verif/tb_tx_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_tx_top
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
